// File: ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Fixed RV32I widths

// Data and address word
`define WORD_W 32

// Register file index, x0..x31
`define REG_IDX_W 5

// Byte lanes per word for memory enables
`define BYTE_LANES 4

`endif

// File: pcmux.sv
`default_nettype none

package pcmux;

  // Next-PC source picked by fetch
  typedef enum logic [1:0] {
    pc_plus4 = 2'b00,
    alu_out  = 2'b01,  // Branch and jal target
    alu_mod2 = 2'b10   // Jalr target with bit 0 cleared
  } pcmux_sel_t;

  // Operand source chosen by the forwarding unit
  typedef enum logic [1:0] {
    fwd_none   = 2'b00,  // Value from ID/EX
    fwd_mem_wb = 2'b01,
    fwd_ex_mem = 2'b10
  } fwd_sel_t;

endpackage

`default_nettype wire

// File: rv32i_types.sv
`default_nettype none

`include "ex_params.svh"

package rv32i_types;

  typedef logic [`WORD_W-1:0]     rv32i_word;
  typedef logic [`REG_IDX_W-1:0]  rv32i_reg;
  typedef logic [`BYTE_LANES-1:0] rv32i_mask;  // One bit per byte lane

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct3_t;

  // Low bits follow funct3, bit 3 is funct7[5]
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_ops;

  // 010 and 011 are left free for slt and sltu
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  typedef struct packed {
    rv32i_opcode       opcode;
    alu_ops            aluop;
    branch_funct3_t    cmpop;
    pcmux::pcmux_sel_t pcmux_sel;
    logic              load_regfile;
    rv32i_reg          rd;
    logic              alu1_is_rs1;
    logic              alu2_is_rs2;
    logic              cmp2_is_rs2;
  } rv32i_control_word;

endpackage

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv32i_types::alu_ops    aluop,
  input  rv32i_types::rv32i_word a,
  input  rv32i_types::rv32i_word b,
  output rv32i_types::rv32i_word f,
  output rv32i_types::rv32i_word alu_out_to_PC
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Only low 5 bits shift

  always_comb begin
    case (aluop)
      rv32i_types::alu_add:  f = a + b;
      rv32i_types::alu_sub:  f = a - b;
      rv32i_types::alu_sll:  f = a << shamt;
      rv32i_types::alu_srl:  f = a >> shamt;
      rv32i_types::alu_sra:  f = rv32i_types::rv32i_word'($signed(a) >>> shamt);
      rv32i_types::alu_slt:  f = rv32i_types::rv32i_word'($signed(a) < $signed(b));
      rv32i_types::alu_sltu: f = rv32i_types::rv32i_word'(a < b);
      rv32i_types::alu_xor:  f = a ^ b;
      rv32i_types::alu_or:   f = a | b;
      rv32i_types::alu_and:  f = a & b;
      default:               f = a + b;  // Unused encodings
    endcase
  end

  // Jalr target
  assign alu_out_to_PC = {f[31:1], 1'b0};

endmodule

`default_nettype wire

// File: cmp.sv
`timescale 1ns/1ps
`default_nettype none

module cmp (
  input  rv32i_types::branch_funct3_t cmpop,
  input  rv32i_types::rv32i_word      cmp_input_1,
  input  rv32i_types::rv32i_word      cmp_input_2,
  output logic                        br_en
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (cmp_input_1 == cmp_input_2);
  assign lt_s = ($signed(cmp_input_1) < $signed(cmp_input_2));
  assign lt_u = (cmp_input_1 < cmp_input_2);

  always_comb begin
    case (cmpop)
      rv32i_types::beq:  br_en = eq;
      rv32i_types::bne:  br_en = !eq;
      rv32i_types::blt:  br_en = lt_s;
      rv32i_types::bge:  br_en = !lt_s;
      rv32i_types::bltu: br_en = lt_u;
      rv32i_types::bgeu: br_en = !lt_u;
      // funct3 010 is slt, 011 is sltu
      default:           br_en = cmpop[0] ? lt_u : lt_s;
    endcase
  end

endmodule

`default_nettype wire

// File: ex_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_forward_unit (
  input  rv32i_types::rv32i_word         instr,
  input  rv32i_types::rv32i_control_word id_ex,
  input  rv32i_types::rv32i_control_word ex_mem,
  input  rv32i_types::rv32i_control_word mem_wb,
  output pcmux::fwd_sel_t                fwd_rs1,
  output pcmux::fwd_sel_t                fwd_rs2
);

  rv32i_types::rv32i_reg rs1_idx;
  rv32i_types::rv32i_reg rs2_idx;
  logic                  uses_rs1;
  logic                  uses_rs2;

  function automatic pcmux::fwd_sel_t pick_source(
    input rv32i_types::rv32i_reg          src,
    input logic                           used,
    input rv32i_types::rv32i_control_word mem_stage,
    input rv32i_types::rv32i_control_word wb_stage
  );
    pcmux::fwd_sel_t sel;
    sel = pcmux::fwd_none;
    if (used && src != '0) begin  // x0 is hardwired zero
      if (mem_stage.load_regfile && mem_stage.rd == src)
        sel = pcmux::fwd_ex_mem;  // Youngest value first
      else if (wb_stage.load_regfile && wb_stage.rd == src)
        sel = pcmux::fwd_mem_wb;
    end
    return sel;
  endfunction

  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  // U and J formats have no rs1 field
  assign uses_rs1 = !(id_ex.opcode inside {rv32i_types::op_lui, rv32i_types::op_auipc,
                                           rv32i_types::op_jal});
  assign uses_rs2 = id_ex.opcode inside {rv32i_types::op_br, rv32i_types::op_store,
                                         rv32i_types::op_reg};

  assign fwd_rs1 = pick_source(rs1_idx, uses_rs1, ex_mem, mem_wb);
  assign fwd_rs2 = pick_source(rs2_idx, uses_rs2, ex_mem, mem_wb);

endmodule

`default_nettype wire

// File: instruction_execute.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_execute (
  input  logic                           clk,
  input  logic                           rst,
  input  rv32i_types::rv32i_word         PC_in,
  input  rv32i_types::rv32i_word         instruction_in,
  input  rv32i_types::rv32i_word         alu_in_1,  // Immediate or PC path
  input  rv32i_types::rv32i_word         alu_in_2,
  input  rv32i_types::rv32i_word         rs1_out,   // Register file reads
  input  rv32i_types::rv32i_word         rs2,
  input  rv32i_types::rv32i_word         cmp_in,
  input  rv32i_types::rv32i_control_word ctrl_word_in,
  input  logic                           MA_stall,
  input  rv32i_types::rv32i_control_word mem_wb,
  input  rv32i_types::rv32i_word         mem_wb_data,

  output rv32i_types::rv32i_control_word ctrl_word_out,
  output rv32i_types::rv32i_word         instruction_out,
  output rv32i_types::rv32i_word         PC_out,
  output rv32i_types::rv32i_word         alu_out,
  output rv32i_types::rv32i_word         rs2_out,
  output logic                           br_en_out,
  output rv32i_types::rv32i_mask         mem_byte_enable_out,
  output rv32i_types::rv32i_word         alu_out_to_PC,
  output pcmux::pcmux_sel_t              pcmux_sel,
  output logic                           br_taken
);

  rv32i_types::rv32i_word alu_f;
  rv32i_types::rv32i_word rs1_val;
  rv32i_types::rv32i_word rs2_val;
  rv32i_types::rv32i_word alu_input_1;
  rv32i_types::rv32i_word alu_input_2;
  rv32i_types::rv32i_word cmp_input_2;
  rv32i_types::rv32i_mask lane_pattern;
  rv32i_types::rv32i_mask mem_byte_enable;
  pcmux::fwd_sel_t        fwd_rs1;
  pcmux::fwd_sel_t        fwd_rs2;
  logic                   br_en;
  logic [2:0]             funct3;

  ex_forward_unit u_ex_forward_unit (
    .instr   (instruction_in),
    .id_ex   (ctrl_word_in),
    .ex_mem  (ctrl_word_out),
    .mem_wb  (mem_wb),
    .fwd_rs1 (fwd_rs1),
    .fwd_rs2 (fwd_rs2)
  );

  always_comb begin
    case (fwd_rs1)
      pcmux::fwd_ex_mem: rs1_val = alu_out;
      pcmux::fwd_mem_wb: rs1_val = mem_wb_data;
      default:           rs1_val = rs1_out;
    endcase
    case (fwd_rs2)
      pcmux::fwd_ex_mem: rs2_val = alu_out;
      pcmux::fwd_mem_wb: rs2_val = mem_wb_data;
      default:           rs2_val = rs2;
    endcase
  end

  assign alu_input_1 = ctrl_word_in.alu1_is_rs1 ? rs1_val : alu_in_1;
  assign alu_input_2 = ctrl_word_in.alu2_is_rs2 ? rs2_val : alu_in_2;
  assign cmp_input_2 = ctrl_word_in.cmp2_is_rs2 ? rs2_val : cmp_in;

  alu u_alu (
    .aluop         (ctrl_word_in.aluop),
    .a             (alu_input_1),
    .b             (alu_input_2),
    .f             (alu_f),
    .alu_out_to_PC (alu_out_to_PC)
  );

  cmp u_cmp (
    .cmpop       (ctrl_word_in.cmpop),
    .cmp_input_1 (rs1_val),
    .cmp_input_2 (cmp_input_2),
    .br_en       (br_en)
  );

  assign br_taken = (ctrl_word_in.opcode == rv32i_types::op_br && br_en) ||
                    ctrl_word_in.opcode == rv32i_types::op_jal ||
                    ctrl_word_in.opcode == rv32i_types::op_jalr;
  assign pcmux_sel = br_taken ? ctrl_word_in.pcmux_sel : pcmux::pc_plus4;

  // Byte enables from access size, shifted to the address offset
  assign funct3 = instruction_in[14:12];

  always_comb begin
    lane_pattern = '0;
    if (ctrl_word_in.opcode == rv32i_types::op_load) begin
      case (rv32i_types::load_funct3_t'(funct3))
        rv32i_types::lb, rv32i_types::lbu: lane_pattern = 4'b0001;
        rv32i_types::lh, rv32i_types::lhu: lane_pattern = 4'b0011;
        rv32i_types::lw:                   lane_pattern = 4'b1111;
        default:                           lane_pattern = '0;
      endcase
    end else if (ctrl_word_in.opcode == rv32i_types::op_store) begin
      case (rv32i_types::store_funct3_t'(funct3))
        rv32i_types::sb: lane_pattern = 4'b0001;
        rv32i_types::sh: lane_pattern = 4'b0011;
        rv32i_types::sw: lane_pattern = 4'b1111;
        default:         lane_pattern = '0;
      endcase
    end
  end

  // Lanes past 3 drop off, so a split access keeps only its low part
  assign mem_byte_enable = lane_pattern << alu_f[1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_word_out       <= '0;  // Clears load_regfile, no stale forwarding
      instruction_out     <= '0;
      PC_out              <= '0;
      alu_out             <= '0;
      rs2_out             <= '0;
      br_en_out           <= 1'b0;
      mem_byte_enable_out <= '0;
    end else if (!MA_stall) begin
      ctrl_word_out       <= ctrl_word_in;
      instruction_out     <= instruction_in;
      PC_out              <= PC_in;
      alu_out             <= alu_f;
      rs2_out             <= rs2_val;  // Store data
      br_en_out           <= br_en;
      mem_byte_enable_out <= mem_byte_enable;
    end
  end

endmodule

`default_nettype wire

// File: instruction_execute_assert.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_execute_assert (
  input logic                           clk,
  input logic                           rst,
  input logic                           MA_stall,
  input rv32i_types::rv32i_control_word ctrl_word_out,
  input rv32i_types::rv32i_word         instruction_out,
  input rv32i_types::rv32i_word         PC_out,
  input rv32i_types::rv32i_word         alu_out,
  input rv32i_types::rv32i_word         rs2_out,
  input logic                           br_en_out,
  input rv32i_types::rv32i_mask         mem_byte_enable_out,
  input rv32i_types::rv32i_word         alu_out_to_PC,
  input pcmux::pcmux_sel_t              pcmux_sel,
  input logic                           br_taken
);

  // Whole EX/MEM register as one vector
  logic [$bits(rv32i_types::rv32i_control_word)+132:0] ex_mem_q;

  assign ex_mem_q = {ctrl_word_out, instruction_out, PC_out, alu_out, rs2_out, br_en_out,
                     mem_byte_enable_out};

  zero_after_reset: assert property (@(posedge clk) $past(rst) |-> ex_mem_q == '0)
    else $error("EX/MEM register not cleared by reset");

  hold_on_stall: assert property (@(posedge clk)
    $past(MA_stall) && !$past(rst) |-> $stable(ex_mem_q))
    else $error("EX/MEM register changed during a memory stall");

  pc_plus4_when_not_taken: assert property (@(posedge clk)
    !br_taken |-> pcmux_sel == pcmux::pc_plus4)
    else $error("pcmux_sel not pc_plus4 while no branch is taken");

  jump_target_aligned: assert property (@(posedge clk) alu_out_to_PC[0] == 1'b0)
    else $error("Jump target has bit 0 set");

endmodule

bind instruction_execute instruction_execute_assert u_instruction_execute_assert (
  .clk (clk), .rst (rst), .MA_stall (MA_stall), .ctrl_word_out (ctrl_word_out),
  .instruction_out (instruction_out), .PC_out (PC_out), .alu_out (alu_out),
  .rs2_out (rs2_out), .br_en_out (br_en_out), .mem_byte_enable_out (mem_byte_enable_out),
  .alu_out_to_PC (alu_out_to_PC), .pcmux_sel (pcmux_sel), .br_taken (br_taken)
);

`default_nettype wire

// File: tb_instruction_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module tb_instruction_execute;

  localparam int ALU_N = 200;
  localparam int LIMIT = 10 * ALU_N + 1000;  // ALU sweep plus directed tests, with margin

  typedef struct packed {
    logic                           rst;
    logic                           stall;
    rv32i_types::rv32i_word         pc;
    rv32i_types::rv32i_word         instr;
    rv32i_types::rv32i_word         a1;
    rv32i_types::rv32i_word         a2;
    rv32i_types::rv32i_word         r1;
    rv32i_types::rv32i_word         r2;
    rv32i_types::rv32i_word         cmp;
    rv32i_types::rv32i_control_word ctrl;
    rv32i_types::rv32i_control_word wb;
    rv32i_types::rv32i_word         wb_data;
  } stim_t;

  typedef struct packed {
    rv32i_types::rv32i_control_word ctrl;
    rv32i_types::rv32i_word         instr;
    rv32i_types::rv32i_word         pc;
    rv32i_types::rv32i_word         alu;
    rv32i_types::rv32i_word         rs2;
    logic                           br_en;
    logic [`BYTE_LANES-1:0]         be;
  } ex_mem_t;

  logic                           clk;
  stim_t                          s;
  ex_mem_t                        got;
  ex_mem_t                        exp_q;  // Model of the EX/MEM register
  rv32i_types::rv32i_control_word ctrl_word_out;
  rv32i_types::rv32i_word         instruction_out;
  rv32i_types::rv32i_word         PC_out;
  rv32i_types::rv32i_word         alu_out;
  rv32i_types::rv32i_word         rs2_out;
  logic                           br_en_out;
  rv32i_types::rv32i_mask         mem_byte_enable_out;
  rv32i_types::rv32i_word         alu_out_to_PC;
  pcmux::pcmux_sel_t              pcmux_sel;
  logic                           br_taken;
  int                             cycles = 0;

  instruction_execute u_instruction_execute (
    .clk (clk), .rst (s.rst), .PC_in (s.pc), .instruction_in (s.instr),
    .alu_in_1 (s.a1), .alu_in_2 (s.a2), .rs1_out (s.r1), .rs2 (s.r2),
    .cmp_in (s.cmp), .ctrl_word_in (s.ctrl), .MA_stall (s.stall),
    .mem_wb (s.wb), .mem_wb_data (s.wb_data),
    .ctrl_word_out (ctrl_word_out), .instruction_out (instruction_out),
    .PC_out (PC_out), .alu_out (alu_out), .rs2_out (rs2_out), .br_en_out (br_en_out),
    .mem_byte_enable_out (mem_byte_enable_out), .alu_out_to_PC (alu_out_to_PC),
    .pcmux_sel (pcmux_sel), .br_taken (br_taken)
  );

  assign got = {ctrl_word_out, instruction_out, PC_out, alu_out, rs2_out, br_en_out,
                mem_byte_enable_out};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  function automatic rv32i_types::rv32i_word alu_model(rv32i_types::alu_ops op,
                                                       rv32i_types::rv32i_word a,
                                                       rv32i_types::rv32i_word b);
    case (op)
      rv32i_types::alu_sub:  return a - b;
      rv32i_types::alu_sll:  return a << b[4:0];
      rv32i_types::alu_srl:  return a >> b[4:0];
      rv32i_types::alu_sra:  return $signed(a) >>> b[4:0];
      rv32i_types::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
      rv32i_types::alu_sltu: return {31'b0, a < b};
      rv32i_types::alu_xor:  return a ^ b;
      rv32i_types::alu_or:   return a | b;
      rv32i_types::alu_and:  return a & b;
      default:               return a + b;
    endcase
  endfunction

  function automatic logic cmp_model(rv32i_types::branch_funct3_t op,
                                     rv32i_types::rv32i_word x, rv32i_types::rv32i_word y);
    case (op)
      rv32i_types::beq:  return x == y;
      rv32i_types::bne:  return x != y;
      rv32i_types::blt:  return $signed(x) < $signed(y);
      rv32i_types::bge:  return $signed(x) >= $signed(y);
      rv32i_types::bltu: return x < y;
      rv32i_types::bgeu: return x >= y;
      // 010 is slt, 011 is sltu
      default:           return op[0] ? (x < y) : ($signed(x) < $signed(y));
    endcase
  endfunction

  function automatic logic [3:0] be_model(rv32i_types::rv32i_opcode opc, logic [2:0] f3,
                                          logic [1:0] k);
    logic [1:0] size;  // 0 byte, 1 half, 2 word, 3 none
    size = 2'd3;
    if (opc == rv32i_types::op_load && f3 != 3'd3 && f3 < 3'd6)
      size = f3[1:0];
    else if (opc == rv32i_types::op_store && f3 < 3'd3)
      size = f3[1:0];
    case (size)
      2'd0: return 4'b0001 << k;
      2'd1: return (k == 2'd0) ? 4'b0011 : (k == 2'd1) ? 4'b0110 :
                   (k == 2'd2) ? 4'b1100 : 4'b1000;
      2'd2: return 4'b1111 << k;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic rv32i_types::rv32i_word fwd(rv32i_types::rv32i_reg src, logic used,
                                                 rv32i_types::rv32i_word dflt, stim_t v);
    if (!used || src == '0)
      return dflt;
    if (exp_q.ctrl.load_regfile && exp_q.ctrl.rd == src)
      return exp_q.alu;  // EX/MEM is younger
    if (v.wb.load_regfile && v.wb.rd == src)
      return v.wb_data;
    return dflt;
  endfunction

  function automatic stim_t rnd();
    stim_t v;
    v = '0;
    v.pc = $urandom;
    v.instr = $urandom;
    v.a1 = $urandom;
    v.a2 = $urandom;
    v.r1 = $urandom;
    v.r2 = $urandom;
    v.cmp = $urandom;
    v.wb_data = $urandom;
    v.ctrl.opcode = rv32i_types::op_reg;
    v.ctrl.aluop = rv32i_types::alu_add;
    v.ctrl.cmpop = rv32i_types::beq;
    v.ctrl.pcmux_sel = pcmux::pc_plus4;
    v.ctrl.rd = 5'($urandom);
    return v;
  endfunction

  task automatic check(input string name, input string field, input logic [255:0] exp,
                       input logic [255:0] act);
    assert (exp == act) else begin
      $display("FAILED %s %s expected %0h actual %0h", name, field, exp, act);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic run(input string name, input stim_t v);
    rv32i_types::rv32i_word rs1_v;
    rv32i_types::rv32i_word rs2_v;
    rv32i_types::rv32i_word f;
    logic                   en;
    logic                   taken;
    rv32i_types::rv32i_opcode opc;
    @(posedge clk);
    s <= v;
    @(negedge clk);
    check(name, "ex_mem", 256'(exp_q), 256'(got));
    opc = v.ctrl.opcode;
    rs1_v = fwd(v.instr[19:15], !(opc inside {rv32i_types::op_lui, rv32i_types::op_auipc,
                rv32i_types::op_jal}), v.r1, v);
    rs2_v = fwd(v.instr[24:20], opc inside {rv32i_types::op_br, rv32i_types::op_store,
                rv32i_types::op_reg}, v.r2, v);
    f = alu_model(v.ctrl.aluop, v.ctrl.alu1_is_rs1 ? rs1_v : v.a1,
                  v.ctrl.alu2_is_rs2 ? rs2_v : v.a2);
    en = cmp_model(v.ctrl.cmpop, rs1_v, v.ctrl.cmp2_is_rs2 ? rs2_v : v.cmp);
    taken = (opc == rv32i_types::op_br && en) || opc == rv32i_types::op_jal ||
            opc == rv32i_types::op_jalr;
    check(name, "alu_out_to_PC", 256'({f[31:1], 1'b0}), 256'(alu_out_to_PC));
    check(name, "br_taken", 256'(taken), 256'(br_taken));
    check(name, "pcmux_sel", 256'(taken ? v.ctrl.pcmux_sel : pcmux::pc_plus4), 256'(pcmux_sel));
    if (v.rst)
      exp_q = '0;
    else if (!v.stall)
      exp_q = {v.ctrl, v.instr, v.pc, f, rs2_v, en, be_model(opc, v.instr[14:12], f[1:0])};
  endtask

  initial begin
    stim_t                       v;
    rv32i_types::alu_ops         op;
    rv32i_types::branch_funct3_t bop;
    void'($urandom(32'h86adc104));
    s = '0;
    s.rst = 1'b1;
    exp_q = '0;
    v = '0;
    v.rst = 1'b1;
    repeat (5) run("reset", v);

    op = op.first();
    do begin
      repeat (ALU_N) begin
        v = rnd();
        v.ctrl.aluop = op;
        v.ctrl.cmpop = rv32i_types::branch_funct3_t'(op[2:0]);  // Decoder passes funct3
        run("alu", v);
      end
      op = op.next();
    end while (op != op.first());

    // Modes: chain through both stages, x0, MEM/WB only, no forwarding
    for (int m = 0; m < 4; m++) begin
      repeat (20) begin
        v = rnd();
        v.ctrl.alu1_is_rs1 = 1'b1;
        v.ctrl.alu2_is_rs2 = 1'b1;
        v.ctrl.load_regfile = (m < 2);
        v.wb.load_regfile = (m < 3);
        v.ctrl.rd = (m == 1) ? 5'd0 : 5'd5;
        v.wb.rd = v.ctrl.rd;
        v.instr[19:15] = v.ctrl.rd;
        v.instr[24:20] = v.ctrl.rd;
        run("forward", v);
      end
    end

    bop = bop.first();
    do begin
      repeat (30) begin
        v = rnd();
        v.ctrl.opcode = rv32i_types::op_br;
        v.ctrl.cmpop = bop;
        v.ctrl.pcmux_sel = pcmux::alu_out;
        v.ctrl.cmp2_is_rs2 = 1'($urandom);
        if ($urandom % 4 == 0) begin
          v.r2 = v.r1;  // Equal operands
          v.cmp = v.r1;
        end
        run("branch", v);
      end
      bop = bop.next();
    end while (bop != bop.first());

    repeat (20) begin
      v = rnd();
      v.ctrl.opcode = 1'($urandom) ? rv32i_types::op_jal : rv32i_types::op_jalr;
      v.ctrl.pcmux_sel = (v.ctrl.opcode == rv32i_types::op_jal) ? pcmux::alu_out
                                                               : pcmux::alu_mod2;
      run("jump", v);
    end

    for (int o = 0; o < 2; o++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int k = 0; k < 4; k++) begin
          v = rnd();
          v.ctrl.opcode = (o == 1) ? rv32i_types::op_store : rv32i_types::op_load;
          v.instr[14:12] = f3[2:0];
          v.a1[1:0] = 2'b00;
          v.a2 = 32'(k);  // Address offset
          run("byte_enable", v);
        end
      end
    end

    repeat (5) run("pre_stall", rnd());
    v = rnd();
    v.stall = 1'b1;
    repeat (5) run("stall", v);  // Same instruction waits in ID/EX
    v.stall = 1'b0;
    run("release", v);
    repeat (2) run("after_release", rnd());
    v = rnd();
    v.rst = 1'b1;
    run("reset_mid", v);
    repeat (2) run("after_reset", rnd());

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
pcmux.sv
rv32i_types.sv
alu.sv
cmp.sv
ex_forward_unit.sv
instruction_execute.sv
instruction_execute_assert.sv
tb_instruction_execute.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_instruction_execute
FILELIST := project.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter-out +%,$(shell cat $(FILELIST))) ex_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
